/* conv_accel.f */
conv_data_pkg.sv
conv_mem_pkg.sv
conv_sequencer.sv
ifm_tile_buffer.sv
conv_mac.sv
ofm_accumulator.sv
conv_top.sv
conv_tb.sv

/* conv_data_pkg.sv */
package conv_data_pkg;

    // pixel and weight width
    localparam int DATA_WIDTH = 8;

    // bias width, sign-extended before it seeds the accumulator
    localparam int BIAS_WIDTH = 16;

    // per-pixel accumulator width
    localparam int ACC_WIDTH = 24;

    // kernel geometry
    localparam int KERNEL_SIZE = 3;
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;

    // zero border around the map
    localparam int PADDING = 1;

endpackage

/* conv_mac.sv */
`timescale 1ns/10ps

module conv_mac #(
    parameter int MAP_SIZE = 8,
    parameter int ROW_W    = 3,
    parameter int PIX_W    = 6
) (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic                                                         kernel_load,
    input  logic [conv_data_pkg::DATA_WIDTH*conv_data_pkg::KERNEL_TAPS-1:0] kernel_readdata,
    input  logic                                                         win_valid,
    input  logic [conv_data_pkg::DATA_WIDTH*conv_data_pkg::KERNEL_TAPS-1:0] window,
    input  logic [ROW_W-1:0]                                             win_row,
    input  logic [ROW_W-1:0]                                             win_col,
    input  logic                                                         first_channel,
    output logic                                                         sum_valid,
    output logic signed [conv_data_pkg::ACC_WIDTH-1:0]                   sum,
    output logic [PIX_W-1:0]                                             sum_index,
    output logic                                                         sum_first
);
    import conv_data_pkg::*;
    import conv_mem_pkg::*;

    logic signed [DATA_WIDTH-1:0]   weight [KERNEL_TAPS];
    logic signed [2*DATA_WIDTH-1:0] prod [KERNEL_TAPS];
    logic signed [ACC_WIDTH-1:0]    prod_sum;
    logic [PIX_W-1:0]               win_index;
    logic [MAC_LATENCY-1:0]         vld_pipe;
    logic [MAC_LATENCY-1:0]         first_pipe;
    logic [PIX_W-1:0]               idx_pipe [MAC_LATENCY];

    always_ff @(posedge clk) begin
        if (kernel_load) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                weight[t] <= kernel_readdata[t*DATA_WIDTH +: DATA_WIDTH];
            end
        end
    end

    // stage one, nine signed products
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                prod[t] <= $signed(window[t*DATA_WIDTH +: DATA_WIDTH]) * weight[t];
            end
        end
    end

    always_comb begin
        prod_sum = '0;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            prod_sum = prod_sum + prod[t];
        end
    end

    // stage two, sign-extended sum
    always_ff @(posedge clk) begin
        if (vld_pipe[0]) begin
            sum <= prod_sum;
        end
    end

    ////////////////////////////////////////////////////////////
    // pixel tag travelling with the data
    ////////////////////////////////////////////////////////////

    assign win_index = PIX_W'(win_row) * PIX_W'(MAP_SIZE) + PIX_W'(win_col);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= win_valid;
            for (int i = 1; i < MAC_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        idx_pipe[0]   <= win_index;
        first_pipe[0] <= first_channel;
        for (int i = 1; i < MAC_LATENCY; i++) begin
            idx_pipe[i]   <= idx_pipe[i-1];
            first_pipe[i] <= first_pipe[i-1];
        end
    end

    assign sum_valid = vld_pipe[MAC_LATENCY-1];
    assign sum_index = idx_pipe[MAC_LATENCY-1];
    assign sum_first = first_pipe[MAC_LATENCY-1];

endmodule

/* conv_mem_pkg.sv */
package conv_mem_pkg;

    // cycles from a read strobe to valid read data
    localparam int RD_LATENCY = 1;

    // conv_mac depth, products then adder tree
    localparam int MAC_LATENCY = 2;

endpackage

/* conv_sequencer.sv */
`timescale 1ns/10ps

module conv_sequencer #(
    parameter int MAP_SIZE      = 8,
    parameter int IN_CHANNELS   = 4,
    parameter int ROW_W         = 3,
    parameter int PIX_W         = 6,
    parameter int IFM_ADDR_W    = 5,
    parameter int KERNEL_ADDR_W = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    output logic                     idle,
    output logic                     finish,
    output logic                     ifm_rd,
    output logic [IFM_ADDR_W-1:0]    ifm_addr,
    output logic                     kernel_rd,
    output logic [KERNEL_ADDR_W-1:0] kernel_addr,
    output logic                     row_write,
    output logic [ROW_W-1:0]         row_index,
    output logic                     kernel_load,
    output logic                     win_valid,
    output logic [ROW_W-1:0]         win_row,
    output logic [ROW_W-1:0]         win_col,
    output logic                     first_channel,
    output logic                     bias_load,
    output logic                     out_read,
    output logic [PIX_W-1:0]         out_index
);
    import conv_mem_pkg::*;

    localparam int CNT_W = $clog2(MAP_SIZE * MAP_SIZE + 1);

    localparam logic [2:0] PH_IDLE    = 3'd0;
    localparam logic [2:0] PH_LOAD    = 3'd1;
    localparam logic [2:0] PH_WAIT    = 3'd2;
    localparam logic [2:0] PH_COMPUTE = 3'd3;
    localparam logic [2:0] PH_DRAIN   = 3'd4;
    localparam logic [2:0] PH_OUTPUT  = 3'd5;

    logic [2:0]               phase;
    logic [CNT_W-1:0]         cnt;
    logic [KERNEL_ADDR_W-1:0] chan;
    logic [ROW_W-1:0]         scan_row;
    logic [ROW_W-1:0]         scan_col;
    logic                     last_step;
    logic                     last_chan;
    logic                     accept;
    logic [RD_LATENCY-1:0]    row_vld_pipe;
    logic [RD_LATENCY-1:0]    kern_vld_pipe;
    logic [ROW_W-1:0]         row_pipe [RD_LATENCY];

    ////////////////////////////////////////////////////////////
    // phase control
    ////////////////////////////////////////////////////////////

    assign accept    = (phase == PH_IDLE) && start;
    assign last_chan = (chan == KERNEL_ADDR_W'(IN_CHANNELS - 1));

    // output phase runs one cycle longer to cover the read latency
    always_comb begin
        case (phase)
            PH_LOAD:    last_step = (cnt == CNT_W'(MAP_SIZE - 1));
            PH_WAIT:    last_step = (cnt == CNT_W'(RD_LATENCY - 1));
            PH_COMPUTE: last_step = (cnt == CNT_W'(MAP_SIZE * MAP_SIZE - 1));
            PH_DRAIN:   last_step = (cnt == CNT_W'(MAC_LATENCY - 1));
            PH_OUTPUT:  last_step = (cnt == CNT_W'(MAP_SIZE * MAP_SIZE));
            default:    last_step = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
            cnt   <= '0;
            chan  <= '0;
        end else if (accept) begin
            phase <= PH_LOAD;
            cnt   <= '0;
            chan  <= '0;
        end else if (phase != PH_IDLE) begin
            if (last_step) begin
                cnt <= '0;
                case (phase)
                    PH_LOAD:    phase <= PH_WAIT;
                    PH_WAIT:    phase <= PH_COMPUTE;
                    PH_COMPUTE: begin
                        if (last_chan) begin
                            phase <= PH_DRAIN;
                        end else begin
                            phase <= PH_LOAD;
                            chan  <= chan + 1'b1;
                        end
                    end
                    PH_DRAIN:   phase <= PH_OUTPUT;
                    default:    phase <= PH_IDLE;
                endcase
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            finish <= 1'b0;
        end else begin
            finish <= (phase == PH_OUTPUT) && last_step;
        end
    end

    ////////////////////////////////////////////////////////////
    // ram reads and read-strobe delay line
    ////////////////////////////////////////////////////////////

    // rows of all channels sit back to back in the ifm ram
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifm_addr <= '0;
        end else if (accept) begin
            ifm_addr <= '0;
        end else if (ifm_rd) begin
            ifm_addr <= ifm_addr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_vld_pipe  <= '0;
            kern_vld_pipe <= '0;
        end else begin
            row_vld_pipe[0]  <= ifm_rd;
            kern_vld_pipe[0] <= kernel_rd;
            for (int i = 1; i < RD_LATENCY; i++) begin
                row_vld_pipe[i]  <= row_vld_pipe[i-1];
                kern_vld_pipe[i] <= kern_vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        row_pipe[0] <= cnt[ROW_W-1:0];
        for (int i = 1; i < RD_LATENCY; i++) begin
            row_pipe[i] <= row_pipe[i-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // raster scan
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_row <= '0;
            scan_col <= '0;
        end else if (phase == PH_COMPUTE) begin
            if (scan_col == ROW_W'(MAP_SIZE - 1)) begin
                scan_col <= '0;
                scan_row <= (scan_row == ROW_W'(MAP_SIZE - 1)) ? '0 : scan_row + 1'b1;
            end else begin
                scan_col <= scan_col + 1'b1;
            end
        end
    end

    assign idle          = (phase == PH_IDLE);
    assign ifm_rd        = (phase == PH_LOAD);
    assign kernel_rd     = (phase == PH_LOAD) && (cnt == '0);
    assign kernel_addr   = chan;
    assign row_write     = row_vld_pipe[RD_LATENCY-1];
    assign row_index     = row_pipe[RD_LATENCY-1];
    assign kernel_load   = kern_vld_pipe[RD_LATENCY-1];
    assign win_valid     = (phase == PH_COMPUTE);
    assign win_row       = scan_row;
    assign win_col       = scan_col;
    assign first_channel = (chan == '0);
    assign bias_load     = accept;
    assign out_read      = (phase == PH_OUTPUT) && (cnt != CNT_W'(MAP_SIZE * MAP_SIZE));
    assign out_index     = cnt[PIX_W-1:0];

    // kernel word goes out with the row 0 read of the same channel
    a_kernel_with_row0: assert property (@(posedge clk) disable iff (!rst_n)
        kernel_rd |-> (ifm_rd && ifm_addr == IFM_ADDR_W'(chan * MAP_SIZE)));

    a_no_window_during_fill: assert property (@(posedge clk) disable iff (!rst_n)
        !(win_valid && row_write));

endmodule

/* conv_tb.sv */
`timescale 1ns/10ps

module conv_tb;
    import conv_data_pkg::*;
    import conv_mem_pkg::*;

    localparam int M           = 8;
    localparam int C           = 4;
    localparam int PIXELS      = M * M;
    localparam int RUN_CYCLES  = C * (M + RD_LATENCY + PIXELS) + MAC_LATENCY + PIXELS + 2;
    localparam int NUM_RUNS    = 6;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * (RUN_CYCLES + 32) + 64;
    localparam int IFM_ADDR_W  = $clog2(C * M);
    localparam int KERN_ADDR_W = (C > 1) ? $clog2(C) : 1;

    logic                                clk;
    logic                                rst_n;
    logic                                start;
    logic [BIAS_WIDTH-1:0]               bias;
    logic                                idle;
    logic                                ifm_rd;
    logic [IFM_ADDR_W-1:0]               ifm_addr;
    logic [DATA_WIDTH*M-1:0]             ifm_readdata;
    logic                                kernel_rd;
    logic [KERN_ADDR_W-1:0]              kernel_addr;
    logic [DATA_WIDTH*KERNEL_TAPS-1:0]   kernel_readdata;
    logic                                ofm_valid;
    logic [ACC_WIDTH-1:0]                ofm_data;
    logic                                finish;

    // ram contents and read pipelines
    logic [DATA_WIDTH*M-1:0]             ifm_mem [C*M];
    logic [DATA_WIDTH*KERNEL_TAPS-1:0]   kernel_mem [C];
    logic [DATA_WIDTH*M-1:0]             ifm_pipe [RD_LATENCY];
    logic [DATA_WIDTH*KERNEL_TAPS-1:0]   kern_pipe [RD_LATENCY];

    logic [ACC_WIDTH-1:0]                exp_map [PIXELS];
    logic [ACC_WIDTH-1:0]                ofm_q [$];
    logic [31:0]                         lfsr_state = 32'he29b4ddc;
    int                                  cycle_count = 0;
    int                                  first_cycle = 0;
    int                                  last_cycle = 0;
    int                                  errors = 0;
    int                                  checks = 0;
    int                                  tests_run = 0;
    int                                  tests_failed = 0;

    conv_top #(.MAP_SIZE(M), .IN_CHANNELS(C)) dut (
        .clk(clk), .rst_n(rst_n), .start(start), .bias(bias), .idle(idle),
        .ifm_rd(ifm_rd), .ifm_addr(ifm_addr), .ifm_readdata(ifm_readdata),
        .kernel_rd(kernel_rd), .kernel_addr(kernel_addr),
        .kernel_readdata(kernel_readdata), .ofm_valid(ofm_valid),
        .ofm_data(ofm_data), .finish(finish)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic report(input int num, input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", num, name, errors - err_before);
        end
    endtask

    task automatic fill_ifm(input bit rnd, input logic [DATA_WIDTH-1:0] value);
        for (int a = 0; a < C * M; a++) begin
            for (int x = 0; x < M; x++) begin
                ifm_mem[a][x*DATA_WIDTH +: DATA_WIDTH] =
                    rnd ? DATA_WIDTH'(rand_bits(DATA_WIDTH)) : value;
            end
        end
    endtask

    task automatic fill_kernels(input bit rnd, input logic [DATA_WIDTH-1:0] value);
        for (int c = 0; c < C; c++) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                kernel_mem[c][t*DATA_WIDTH +: DATA_WIDTH] =
                    rnd ? DATA_WIDTH'(rand_bits(DATA_WIDTH)) : value;
            end
        end
    endtask

    // reference model, straight from the convolution rule
    task automatic build_expected(input logic [BIAS_WIDTH-1:0] b);
        int acc;
        int yy;
        int xx;
        logic signed [DATA_WIDTH-1:0] p;
        logic signed [DATA_WIDTH-1:0] w;
        for (int y = 0; y < M; y++) begin
            for (int x = 0; x < M; x++) begin
                acc = int'($signed(b));
                for (int c = 0; c < C; c++) begin
                    for (int r = 0; r < 3; r++) begin
                        for (int k = 0; k < 3; k++) begin
                            yy = y + r - 1;
                            xx = x + k - 1;
                            if (yy >= 0 && yy < M && xx >= 0 && xx < M) begin
                                p = ifm_mem[c*M + yy][xx*DATA_WIDTH +: DATA_WIDTH];
                                w = kernel_mem[c][(r*3 + k)*DATA_WIDTH +: DATA_WIDTH];
                                acc = acc + int'(p) * int'(w);
                            end
                        end
                    end
                end
                exp_map[y*M + x] = ACC_WIDTH'(acc);
            end
        end
    endtask

    // start one run and wait for finish, optional stray start at cycle stray_at
    task automatic run_conv(input logic [BIAS_WIDTH-1:0] b, input int stray_at);
        int n;
        ofm_q.delete();
        start = 1'b1;
        bias  = b;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n == 1) begin
                start = 1'b0;
                bias  = BIAS_WIDTH'(rand_bits(BIAS_WIDTH));
            end
            if (stray_at > 0 && n == stray_at) begin
                check("idle at stray start", idle, 0);
                start = 1'b1;
            end
            if (stray_at > 0 && n == stray_at + 1) begin
                start = 1'b0;
            end
        end while (!finish);
        check("run length in cycles", n, RUN_CYCLES);
    endtask

    task automatic verify_map();
        int n;
        n = ofm_q.size();
        check("pixels before finish", n, PIXELS);
        check("stream length in cycles", last_cycle - first_cycle + 1, PIXELS);
        for (int i = 0; i < n && i < PIXELS; i++) begin
            check($sformatf("pixel (%0d,%0d)", i / M, i % M), 32'(ofm_q[i]), 32'(exp_map[i]));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // ram models, collector, monitors
    ////////////////////////////////////////////////////////////

    // data shows up RD_LATENCY cycles after the strobe
    always @(negedge clk) begin
        ifm_readdata    = ifm_pipe[RD_LATENCY-1];
        kernel_readdata = kern_pipe[RD_LATENCY-1];
        for (int i = RD_LATENCY - 1; i > 0; i--) begin
            ifm_pipe[i]  = ifm_pipe[i-1];
            kern_pipe[i] = kern_pipe[i-1];
        end
        ifm_pipe[0]  = ifm_rd ? ifm_mem[ifm_addr] : '0;
        kern_pipe[0] = kernel_rd ? kernel_mem[kernel_addr] : '0;
    end

    always @(negedge clk) begin
        if (ofm_valid) begin
            if (ofm_q.size() == 0) begin
                first_cycle = cycle_count;
            end
            last_cycle = cycle_count;
            ofm_q.push_back(ofm_data);
        end
        if (rst_n && idle) begin
            check("ifm_rd while idle", ifm_rd, 0);
            check("ofm_valid while idle", ofm_valid, 0);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin
        int err0;
        logic [BIAS_WIDTH-1:0] b;
        rst_n = 1'b0;
        start = 1'b0;
        bias = '0;
        ifm_readdata = '0;
        kernel_readdata = '0;
        for (int i = 0; i < RD_LATENCY; i++) begin
            ifm_pipe[i]  = '0;
            kern_pipe[i] = '0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        err0 = errors;
        check("idle after reset", idle, 1);
        check("ifm_rd after reset", ifm_rd, 0);
        check("kernel_rd after reset", kernel_rd, 0);
        check("ofm_valid after reset", ofm_valid, 0);
        check("finish after reset", finish, 0);
        report(0, "reset state", err0);

        err0 = errors;
        fill_ifm(1'b1, '0);
        fill_kernels(1'b1, '0);
        b = BIAS_WIDTH'(rand_bits(BIAS_WIDTH));
        build_expected(b);
        run_conv(b, 0);
        verify_map();
        report(1, "random maps", err0);

        // zero map leaves only the bias
        err0 = errors;
        fill_ifm(1'b0, '0);
        fill_kernels(1'b1, '0);
        b = BIAS_WIDTH'(rand_bits(BIAS_WIDTH));
        for (int i = 0; i < PIXELS; i++) begin
            exp_map[i] = ACC_WIDTH'($signed(b));
        end
        run_conv(b, 0);
        verify_map();
        report(2, "zero map", err0);

        // all ones, so each pixel counts its in-map taps
        err0 = errors;
        fill_ifm(1'b0, 8'd1);
        fill_kernels(1'b0, 8'd1);
        b = BIAS_WIDTH'(rand_bits(BIAS_WIDTH));
        for (int y = 0; y < M; y++) begin
            for (int x = 0; x < M; x++) begin
                if ((y == 0 || y == M - 1) && (x == 0 || x == M - 1)) begin
                    exp_map[y*M + x] = ACC_WIDTH'(int'($signed(b)) + 4 * C);
                end else if (y == 0 || y == M - 1 || x == 0 || x == M - 1) begin
                    exp_map[y*M + x] = ACC_WIDTH'(int'($signed(b)) + 6 * C);
                end else begin
                    exp_map[y*M + x] = ACC_WIDTH'(int'($signed(b)) + 9 * C);
                end
            end
        end
        run_conv(b, 0);
        verify_map();
        report(3, "zero padding", err0);

        err0 = errors;
        fill_ifm(1'b1, '0);
        fill_kernels(1'b1, '0);
        b = BIAS_WIDTH'(rand_bits(BIAS_WIDTH));
        build_expected(b);
        run_conv(b, RUN_CYCLES / 3);
        verify_map();
        repeat (16) begin
            @(negedge clk);
            check("finish after run end", finish, 0);
            check("idle after run end", idle, 1);
        end
        report(4, "start during run", err0);

        err0 = errors;
        for (int k = 0; k < 2; k++) begin
            fill_ifm(1'b1, '0);
            fill_kernels(1'b1, '0);
            b = BIAS_WIDTH'(rand_bits(BIAS_WIDTH));
            build_expected(b);
            run_conv(b, 0);
            verify_map();
            check("idle between runs", idle, 1);
        end
        report(5, "back to back runs", err0);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* conv_top.sv */
`timescale 1ns/10ps

module conv_top #(
    parameter int  MAP_SIZE      = 8,
    parameter int  IN_CHANNELS   = 4,
    localparam int ROW_W         = $clog2(MAP_SIZE),
    localparam int PIX_W         = $clog2(MAP_SIZE * MAP_SIZE),
    localparam int IFM_ADDR_W    = $clog2(IN_CHANNELS * MAP_SIZE),
    localparam int KERNEL_ADDR_W = (IN_CHANNELS > 1) ? $clog2(IN_CHANNELS) : 1
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  start,
    input  logic [conv_data_pkg::BIAS_WIDTH-1:0]                  bias,
    output logic                                                  idle,
    output logic                                                  ifm_rd,
    output logic [IFM_ADDR_W-1:0]                                 ifm_addr,
    input  logic [conv_data_pkg::DATA_WIDTH*MAP_SIZE-1:0]         ifm_readdata,
    output logic                                                  kernel_rd,
    output logic [KERNEL_ADDR_W-1:0]                              kernel_addr,
    input  logic [conv_data_pkg::DATA_WIDTH*conv_data_pkg::KERNEL_TAPS-1:0] kernel_readdata,
    output logic                                                  ofm_valid,
    output logic [conv_data_pkg::ACC_WIDTH-1:0]                   ofm_data,
    output logic                                                  finish
);
    import conv_data_pkg::*;

    logic                             row_write;
    logic [ROW_W-1:0]                 row_index;
    logic                             kernel_load;
    logic                             win_valid;
    logic [ROW_W-1:0]                 win_row;
    logic [ROW_W-1:0]                 win_col;
    logic                             first_channel;
    logic                             bias_load;
    logic                             out_read;
    logic [PIX_W-1:0]                 out_index;
    logic [DATA_WIDTH*KERNEL_TAPS-1:0] window;
    logic                             sum_valid;
    logic signed [ACC_WIDTH-1:0]      sum;
    logic [PIX_W-1:0]                 sum_index;
    logic                             sum_first;

    conv_sequencer #(
        .MAP_SIZE(MAP_SIZE), .IN_CHANNELS(IN_CHANNELS), .ROW_W(ROW_W), .PIX_W(PIX_W),
        .IFM_ADDR_W(IFM_ADDR_W), .KERNEL_ADDR_W(KERNEL_ADDR_W)
    ) u_sequencer (
        .clk(clk), .rst_n(rst_n), .start(start), .idle(idle), .finish(finish),
        .ifm_rd(ifm_rd), .ifm_addr(ifm_addr), .kernel_rd(kernel_rd),
        .kernel_addr(kernel_addr), .row_write(row_write), .row_index(row_index),
        .kernel_load(kernel_load), .win_valid(win_valid), .win_row(win_row),
        .win_col(win_col), .first_channel(first_channel), .bias_load(bias_load),
        .out_read(out_read), .out_index(out_index)
    );

    ifm_tile_buffer #(.MAP_SIZE(MAP_SIZE), .ROW_W(ROW_W)) u_tile_buffer (
        .clk(clk), .rst_n(rst_n), .row_write(row_write), .row_index(row_index),
        .ifm_readdata(ifm_readdata), .win_row(win_row), .win_col(win_col),
        .window(window)
    );

    conv_mac #(.MAP_SIZE(MAP_SIZE), .ROW_W(ROW_W), .PIX_W(PIX_W)) u_mac (
        .clk(clk), .rst_n(rst_n), .kernel_load(kernel_load),
        .kernel_readdata(kernel_readdata), .win_valid(win_valid), .window(window),
        .win_row(win_row), .win_col(win_col), .first_channel(first_channel),
        .sum_valid(sum_valid), .sum(sum), .sum_index(sum_index), .sum_first(sum_first)
    );

    ofm_accumulator #(.MAP_SIZE(MAP_SIZE), .PIX_W(PIX_W)) u_accumulator (
        .clk(clk), .rst_n(rst_n), .bias_load(bias_load), .bias(bias),
        .sum_valid(sum_valid), .sum(sum), .sum_index(sum_index), .sum_first(sum_first),
        .out_read(out_read), .out_index(out_index), .ofm_valid(ofm_valid),
        .ofm_data(ofm_data)
    );

endmodule

/* ifm_tile_buffer.sv */
`timescale 1ns/10ps

module ifm_tile_buffer #(
    parameter int MAP_SIZE = 8,
    parameter int ROW_W    = 3
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          row_write,
    input  logic [ROW_W-1:0]                              row_index,
    input  logic [conv_data_pkg::DATA_WIDTH*MAP_SIZE-1:0] ifm_readdata,
    input  logic [ROW_W-1:0]                              win_row,
    input  logic [ROW_W-1:0]                              win_col,
    output logic [conv_data_pkg::DATA_WIDTH*conv_data_pkg::KERNEL_TAPS-1:0] window
);
    import conv_data_pkg::*;

    // one map row per entry, column 0 in the low bits
    logic [DATA_WIDTH*MAP_SIZE-1:0] rows [MAP_SIZE];

    always_ff @(posedge clk) begin
        if (row_write) begin
            rows[row_index] <= ifm_readdata;
        end
    end

    // taps outside the map read as zero
    always_comb begin
        int y;
        int x;
        window = '0;
        for (int r = 0; r < KERNEL_SIZE; r++) begin
            for (int c = 0; c < KERNEL_SIZE; c++) begin
                y = int'(win_row) + r - PADDING;
                x = int'(win_col) + c - PADDING;
                if (y >= 0 && y < MAP_SIZE && x >= 0 && x < MAP_SIZE) begin
                    window[(r*KERNEL_SIZE + c)*DATA_WIDTH +: DATA_WIDTH] =
                        rows[y][x*DATA_WIDTH +: DATA_WIDTH];
                end
            end
        end
    end

    a_row_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        row_write |-> (row_index < MAP_SIZE));

endmodule

/* ofm_accumulator.sv */
`timescale 1ns/10ps

module ofm_accumulator #(
    parameter int MAP_SIZE = 8,
    parameter int PIX_W    = 6
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       bias_load,
    input  logic signed [conv_data_pkg::BIAS_WIDTH-1:0] bias,
    input  logic                                       sum_valid,
    input  logic signed [conv_data_pkg::ACC_WIDTH-1:0]  sum,
    input  logic [PIX_W-1:0]                           sum_index,
    input  logic                                       sum_first,
    input  logic                                       out_read,
    input  logic [PIX_W-1:0]                           out_index,
    output logic                                       ofm_valid,
    output logic [conv_data_pkg::ACC_WIDTH-1:0]         ofm_data
);
    import conv_data_pkg::*;

    logic signed [BIAS_WIDTH-1:0] bias_q;
    logic signed [ACC_WIDTH-1:0]  acc_mem [MAP_SIZE*MAP_SIZE];
    logic signed [ACC_WIDTH-1:0]  acc_base;

    always_ff @(posedge clk) begin
        if (bias_load) begin
            bias_q <= bias;
        end
    end

    ////////////////////////////////////////////////////////////
    // accumulate
    ////////////////////////////////////////////////////////////

    // first channel seeds the entry with the bias
    assign acc_base = sum_first ? ACC_WIDTH'(bias_q) : acc_mem[sum_index];

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            acc_mem[sum_index] <= acc_base + sum;
        end
    end

    ////////////////////////////////////////////////////////////
    // output stream
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_valid <= 1'b0;
        end else begin
            ofm_valid <= out_read;
        end
    end

    always_ff @(posedge clk) begin
        if (out_read) begin
            ofm_data <= acc_mem[out_index];
        end
    end

    // pipeline must be empty before the read-out starts
    a_no_add_during_read: assert property (@(posedge clk) disable iff (!rst_n)
        !(sum_valid && out_read));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the conv_accel testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module conv_tb \
    -f conv_accel.f -o conv_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/conv_sim > sim.log 2>&1 ; cat sim.log

grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
